//--- Makefile
# Verilator build and run for the memory subsystem

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
RTL_TOP   ?= mem_subsys_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "** FAIL **" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "** PASS **" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/mem_bist_if.sv
/*
  BIST access stream from the pattern generator to the memory wrapper,
  plus the expected word for the checker.
  The checker also takes the address so it can log the failing one.
*/
`timescale 1ns/100ps

interface mem_bist_if;
   import mem_pkg::*;

   logic      bist_en;    // bist owns the array
   logic      bist_we;    // write strobe
   mem_data_t bist_wem;   // per bit write mask
   mem_addr_t bist_addr;  // shared read/write address
   mem_data_t bist_din;   // write word
   logic      bist_re;    // read strobe
   mem_data_t bist_exp;   // expected read word, same cycle as bist_re

   modport gen (output bist_en, bist_we, bist_wem, bist_addr, bist_din, bist_re, bist_exp);
   modport mem (input  bist_en, bist_we, bist_wem, bist_addr, bist_din, bist_re);
   modport chk (input  bist_re, bist_exp, bist_addr);

endinterface

//--- common/mem_pkg.sv
/*
  Shared definitions for the BIST memory subsystem.
  MEM_DEPTH must stay a power of two, since the BIST address counter
  relies on MEM_AW covering the array exactly.
  The BIST word layout assumes MEM_DW is 32 bits (four address bytes).
*/
package mem_pkg;

   // ####################
   // geometry
   // ####################
   localparam int MEM_DW    = 32;                  // data width
   localparam int MEM_DEPTH = 32;                  // words in array
   localparam int MEM_AW    = $clog2(MEM_DEPTH);   // address width, 5

   typedef logic [MEM_DW-1:0] mem_data_t;          // data word, also bit mask
   typedef logic [MEM_AW-1:0] mem_addr_t;          // word address

   localparam mem_addr_t MEM_LAST = mem_addr_t'(MEM_DEPTH - 1); // top address

   // ####################
   // bist
   // ####################
   localparam mem_data_t BIST_PAT0 = 32'h5555_5555; // pass 0 background
   localparam mem_data_t BIST_PAT1 = 32'hAAAA_AAAA; // pass 1 background

   typedef enum logic [2:0] {
      BIST_IDLE,   // waiting for start
      BIST_WR0,    // write pass 0
      BIST_RD0,    // read back pass 0
      BIST_WR1,    // write pass 1
      BIST_RD1,    // read back pass 1
      BIST_DRAIN   // last read still in flight
   } bist_state_t;

   // address byte repeated in every lane, xored with the pass background
   function automatic mem_data_t bist_word(input mem_addr_t addr, input logic pass1);
      mem_data_t base;
      base = {4{8'(addr)}};                        // zero extend to a byte
      return base ^ (pass1 ? BIST_PAT1 : BIST_PAT0);
   endfunction

endpackage

//--- compile.f
common/mem_pkg.sv
common/mem_bist_if.sv
memory/mem_ram.sv
memory/mem_dp.sv
memory/mem_bist_ctrl.sv
memory/mem_bist_pattern.sv
memory/mem_bist_check.sv
src/mem_subsys_top.sv
dv/tb_mem_subsys.sv

//--- dv/tb_mem_subsys.sv
/*
  Table driven testbench for mem_subsys_top.
  Inputs are driven with NBAs on the rising edge, outputs sampled on the
  falling edge. A model array predicts every functional read; the BIST
  words are rebuilt here from the address byte and pass background.
*/
`timescale 1ns/100ps

module tb_mem_subsys;
   import mem_pkg::*;

   localparam logic [1:0] OP_NOP = 2'd0;
   localparam logic [1:0] OP_WR  = 2'd1;
   localparam logic [1:0] OP_RD  = 2'd2;
   localparam int BIST_TIMEOUT   = 8 * MEM_DEPTH + 32; // cycles to wait for done

   typedef struct packed {
      logic [1:0] op;
      mem_addr_t  addr;
      mem_data_t  mask;
      mem_data_t  data;
      logic       sd;        // shutdown during this access
   } entry_t;

   logic      clk = 1'b0;
   logic      rst_n;
   logic      shutdown;
   logic      wr_en;
   mem_data_t wr_wem;
   mem_addr_t wr_addr;
   mem_data_t wr_din;
   logic      rd_en;
   mem_addr_t rd_addr;
   mem_data_t rd_dout;
   logic      bist_start;
   logic      bist_busy;
   logic      bist_done;
   logic      bist_fail;
   mem_addr_t bist_fail_addr;

   entry_t    tbl [$];              // stimulus table
   mem_data_t model [MEM_DEPTH];    // reference array
   integer    seed = 32'h89a7_34d8;
   int        errors = 0;
   int        checks = 0;

   always #4 clk = ~clk;            // 8 ns period

   mem_subsys_top UUT (
      .clk            (clk),
      .rst_n          (rst_n),
      .shutdown       (shutdown),
      .wr_en          (wr_en),
      .wr_wem         (wr_wem),
      .wr_addr        (wr_addr),
      .wr_din         (wr_din),
      .rd_en          (rd_en),
      .rd_addr        (rd_addr),
      .rd_dout        (rd_dout),
      .bist_start     (bist_start),
      .bist_busy      (bist_busy),
      .bist_done      (bist_done),
      .bist_fail      (bist_fail),
      .bist_fail_addr (bist_fail_addr)
   );

   // ####################
   // compare tasks
   // ####################
   task automatic check_data(input string name, input mem_data_t got, input mem_data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got %h expected %h", name, got, exp);
      end
   endtask

   // ####################
   // table handling
   // ####################
   task automatic push_entry(input logic [1:0] op, input mem_addr_t addr,
                             input mem_data_t mask, input mem_data_t data, input logic sd);
      entry_t e;
      e = '{op: op, addr: addr, mask: mask, data: data, sd: sd};
      tbl.push_back(e);
   endtask

   task automatic build_func_table();
      mem_addr_t a;
      for (int i = 0; i < MEM_DEPTH; i++) begin
         push_entry(OP_WR, mem_addr_t'(i), '1, $random(seed), 1'b0); // defined background
      end
      for (int i = 0; i < MEM_DEPTH; i++) begin
         a = mem_addr_t'($random(seed));
         push_entry(OP_WR, a, $random(seed), $random(seed), 1'b0);   // random mask
         push_entry(OP_RD, a, '0, '0, 1'b0);                         // read straight back
      end
      for (int i = 0; i < MEM_DEPTH; i++) begin
         push_entry(OP_RD, mem_addr_t'(i), '0, '0, 1'b0);
      end
      for (int i = 0; i < 8; i++) begin
         a = mem_addr_t'($random(seed));
         push_entry(OP_WR, a, '1, $random(seed), 1'b1);  // blocked write
         push_entry(OP_RD, a, '0, '0, 1'b1);             // zero load
         push_entry(OP_RD, a, '0, '0, 1'b0);             // old word still there
      end
   endtask

   // one entry per cycle; read data checked on the next falling edge
   task automatic apply_table();
      entry_t    e;
      logic      prev_rd;
      mem_data_t prev_exp;
      logic      have_last;
      mem_data_t last_exp;
      prev_rd   = 1'b0;
      prev_exp  = '0;
      have_last = 1'b0;
      last_exp  = '0;
      while (tbl.size() > 0) begin
         e = tbl.pop_front();
         @(posedge clk);
         shutdown <= e.sd;
         wr_en    <= (e.op == OP_WR);
         wr_wem   <= e.mask;
         wr_addr  <= e.addr;
         wr_din   <= e.data;
         rd_en    <= (e.op == OP_RD);
         rd_addr  <= e.addr;
         @(negedge clk);
         if (prev_rd) begin
            last_exp  = prev_exp;
            have_last = 1'b1;
         end
         if (have_last) check_data("rd_dout", rd_dout, last_exp); // also covers hold
         prev_rd  = (e.op == OP_RD);
         prev_exp = e.sd ? '0 : model[e.addr];
         if (e.op == OP_WR && !e.sd) begin
            model[e.addr] = (model[e.addr] & ~e.mask) | (e.data & e.mask);
         end
      end
      @(posedge clk);
      wr_en    <= 1'b0;
      rd_en    <= 1'b0;
      shutdown <= 1'b0;
      @(negedge clk);
      if (prev_rd) check_data("rd_dout", rd_dout, prev_exp);
   endtask

   // pass 1 word: address byte in each lane, xored with the pass 1 background
   task automatic readback_pass1();
      for (int i = 0; i < MEM_DEPTH; i++) begin
         model[i] = (mem_data_t'(i) * 32'h0101_0101) ^ BIST_PAT1;
         push_entry(OP_RD, mem_addr_t'(i), '0, '0, 1'b0);
      end
      apply_table();
   endtask

   // ####################
   // bist run
   // ####################
   task automatic run_bist(input logic sd, input logic noise, input logic exp_fail);
      int        cycles;
      logic      seen;
      mem_data_t held;
      @(posedge clk);
      shutdown   <= sd;
      bist_start <= 1'b1;
      wr_en      <= 1'b0;
      rd_en      <= 1'b0;
      @(negedge clk);
      held   = rd_dout;               // must survive the whole run
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < BIST_TIMEOUT) begin
         @(posedge clk);
         bist_start <= 1'b0;
         if (noise && cycles < 4 * MEM_DEPTH - 4) begin   // stays clear of the drain
            wr_en   <= 1'b1;
            wr_wem  <= '1;
            wr_addr <= mem_addr_t'($random(seed));
            wr_din  <= $random(seed);
            rd_en   <= 1'b1;
            rd_addr <= mem_addr_t'($random(seed));
         end else begin
            wr_en <= 1'b0;
            rd_en <= 1'b0;
         end
         @(negedge clk);
         cycles++;
         check_data("rd_dout", rd_dout, held);
         if (bist_done) seen = 1'b1;
         else check_flag("bist_busy", bist_busy, 1'b1);
      end
      if (!seen) begin
         errors++;
         $display("bist_done did not arrive within %0d cycles", BIST_TIMEOUT);
      end else begin
         check_flag("bist_busy", bist_busy, 1'b0);
         check_flag("bist_fail", bist_fail, exp_fail);
         if (exp_fail) check_addr("bist_fail_addr", bist_fail_addr, mem_addr_t'(0));
      end
      @(posedge clk);
      wr_en    <= 1'b0;
      rd_en    <= 1'b0;
      shutdown <= 1'b0;
      @(negedge clk);
      if (seen) check_flag("bist_done", bist_done, 1'b0);   // one cycle pulse
   endtask

   // ####################
   // main sequence
   // ####################
   initial begin
      rst_n      = 1'b0;
      shutdown   = 1'b0;
      wr_en      = 1'b0;
      wr_wem     = '0;
      wr_addr    = '0;
      wr_din     = '0;
      rd_en      = 1'b0;
      rd_addr    = '0;
      bist_start = 1'b0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_flag("bist_busy", bist_busy, 1'b0);
      check_flag("bist_done", bist_done, 1'b0);
      check_flag("bist_fail", bist_fail, 1'b0);
      check_addr("bist_fail_addr", bist_fail_addr, mem_addr_t'(0));
      check_data("rd_dout", rd_dout, '0);

      build_func_table();
      apply_table();                  // masked writes, reads, shutdown
      run_bist(1'b0, 1'b1, 1'b0);     // clean run with functional noise
      readback_pass1();
      run_bist(1'b1, 1'b0, 1'b1);     // shutdown held, must fail at 0
      run_bist(1'b0, 1'b0, 1'b0);     // clean run clears the flag
      readback_pass1();

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- memory/mem_bist_check.sv
/*
  BIST read checker.
  Strobe, expected word and address are delayed one cycle to line up
  with the registered read data. The fail flag is sticky and the first
  failing address is kept until the next clear.
*/
`timescale 1ns/100ps

module mem_bist_check (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               clear,          // start of a run
   input  mem_pkg::mem_data_t rd_dout,        // wrapper read data
   mem_bist_if.chk            bist,
   output logic               bist_fail,
   output mem_pkg::mem_addr_t bist_fail_addr
);
   import mem_pkg::*;

   logic      re_q;       // read data valid this cycle
   mem_data_t exp_q;
   mem_addr_t addr_q;
   logic      mismatch;

   // ####################
   // align with read latency
   // ####################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         re_q <= 1'b0;
      end else begin
         re_q <= bist.bist_re;
      end
   end

   always_ff @(posedge clk) begin
      exp_q  <= bist.bist_exp;
      addr_q <= bist.bist_addr;
   end

   assign mismatch = re_q && (rd_dout != exp_q);

   // ####################
   // sticky result
   // ####################
   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         bist_fail      <= 1'b0;
         bist_fail_addr <= '0;
      end else if (mismatch && !bist_fail) begin
         bist_fail      <= 1'b1;
         bist_fail_addr <= addr_q;       // first one only
      end
   end

endmodule

//--- memory/mem_bist_ctrl.sv
/*
  BIST sequencer: write pass 0, read pass 0, write pass 1, read pass 1,
  then one drain cycle for the read latency before done.
  bist_start is taken only in idle; it is ignored while a run is busy.
  chk_clear is combinational and pulses in the cycle start is accepted.
*/
`timescale 1ns/100ps

module mem_bist_ctrl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 bist_start, // one cycle pulse
   input  logic                 addr_last,  // counter at top address
   output mem_pkg::bist_state_t state,
   output logic                 bist_busy,
   output logic                 bist_done,  // one cycle pulse
   output logic                 chk_clear   // clears checker at start
);
   import mem_pkg::*;

   bist_state_t state_nxt;

   // ####################
   // next state
   // ####################
   always_comb begin
      state_nxt = state;
      unique case (state)
         BIST_IDLE:  if (bist_start) state_nxt = BIST_WR0;
         BIST_WR0:   if (addr_last)  state_nxt = BIST_RD0;
         BIST_RD0:   if (addr_last)  state_nxt = BIST_WR1;
         BIST_WR1:   if (addr_last)  state_nxt = BIST_RD1;
         BIST_RD1:   if (addr_last)  state_nxt = BIST_DRAIN;
         BIST_DRAIN: state_nxt = BIST_IDLE;  // last compare lands here
         default:    state_nxt = BIST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= BIST_IDLE;
         bist_done <= 1'b0;
      end else begin
         state     <= state_nxt;
         bist_done <= (state == BIST_DRAIN); // with the return to idle
      end
   end

   assign bist_busy = (state != BIST_IDLE);
   assign chk_clear = (state == BIST_IDLE) && bist_start;

   // done never stretches past one cycle
   a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      bist_done |=> !bist_done)
      else $error("mem_bist_ctrl: bist_done longer than one cycle");

endmodule

//--- memory/mem_bist_pattern.sv
/*
  BIST address counter and data generator.
  The counter runs 0 to MEM_DEPTH-1 once per pass and is zero outside
  the passes, so every state change starts at address 0.
  Write word and expected word are the same function of address and pass.
*/
`timescale 1ns/100ps

module mem_bist_pattern (
   input  logic                 clk,
   input  logic                 rst_n,
   input  mem_pkg::bist_state_t state,
   output logic                 addr_last,  // counter holds top address
   mem_bist_if.gen              bist
);
   import mem_pkg::*;

   mem_addr_t addr_q;
   logic      in_pass;    // one of the four walking states
   logic      pass1;      // second background
   mem_data_t word;

   assign in_pass   = state inside {BIST_WR0, BIST_RD0, BIST_WR1, BIST_RD1};
   assign pass1     = state inside {BIST_WR1, BIST_RD1};
   assign addr_last = (addr_q == MEM_LAST);

   // ####################
   // address counter
   // ####################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         addr_q <= '0;
      end else if (!in_pass || addr_last) begin
         addr_q <= '0;                    // restart for the next pass
      end else begin
         addr_q <= addr_q + 1'b1;
      end
   end

   assign word = bist_word(addr_q, pass1);

   // ####################
   // access stream
   // ####################
   assign bist.bist_en   = (state != BIST_IDLE); // held through drain
   assign bist.bist_we   = (state == BIST_WR0) || (state == BIST_WR1);
   assign bist.bist_re   = (state == BIST_RD0) || (state == BIST_RD1);
   assign bist.bist_wem  = '1;                     // full word writes
   assign bist.bist_addr = addr_q;
   assign bist.bist_din  = word;
   assign bist.bist_exp  = word;                   // checker delays it

endmodule

//--- memory/mem_dp.sv
/*
  Dual port wrapper around mem_ram.
  While bist_en is high the BIST stream owns both ports and functional
  accesses are dropped. Shutdown blocks every write and turns any read
  into a zero load, which holds until the next read.
*/
`timescale 1ns/100ps

module mem_dp (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               shutdown,  // from always-on domain
   input  logic               wr_en,
   input  mem_pkg::mem_data_t wr_wem,
   input  mem_pkg::mem_addr_t wr_addr,
   input  mem_pkg::mem_data_t wr_din,
   input  logic               rd_en,
   input  mem_pkg::mem_addr_t rd_addr,
   output mem_pkg::mem_data_t rd_dout,   // zero after a shutdown read
   mem_bist_if.mem            bist
);
   import mem_pkg::*;

   logic      we_sel;      // write strobe before shutdown
   logic      re_sel;      // read strobe before shutdown
   mem_data_t wem_sel;
   mem_addr_t waddr_sel;
   mem_addr_t raddr_sel;
   mem_data_t din_sel;
   mem_data_t ram_dout;
   logic      zero_q;      // last read happened in shutdown

   // ####################
   // port select
   // ####################
   assign we_sel    = bist.bist_en ? bist.bist_we   : wr_en;
   assign wem_sel   = bist.bist_en ? bist.bist_wem  : wr_wem;
   assign waddr_sel = bist.bist_en ? bist.bist_addr : wr_addr;
   assign din_sel   = bist.bist_en ? bist.bist_din  : wr_din;
   assign re_sel    = bist.bist_en ? bist.bist_re   : rd_en;
   assign raddr_sel = bist.bist_en ? bist.bist_addr : rd_addr; // bist shares one address

   mem_ram u_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (we_sel & ~shutdown),      // shutdown blocks writes
      .wr_wem  (wem_sel),
      .wr_addr (waddr_sel),
      .wr_din  (din_sel),
      .rd_en   (re_sel & ~shutdown),      // array not touched in shutdown
      .rd_addr (raddr_sel),
      .rd_dout (ram_dout)
   );

   // ####################
   // shutdown zero load
   // ####################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         zero_q <= 1'b0;
      end else if (re_sel) begin
         zero_q <= shutdown;              // each read decides again
      end
   end

   assign rd_dout = zero_q ? '0 : ram_dout;

endmodule

//--- memory/mem_ram.sv
/*
  Storage array with per bit write mask and one registered read port.
  Read data appears after the edge that samples rd_en and holds until
  the next read. Only rd_dout is reset; array contents are not.
  Write and read to the same address on one edge returns the old word.
*/
`timescale 1ns/100ps

module mem_ram (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               wr_en,     // write strobe
   input  mem_pkg::mem_data_t wr_wem,    // bit mask, 1 = write
   input  mem_pkg::mem_addr_t wr_addr,
   input  mem_pkg::mem_data_t wr_din,
   input  logic               rd_en,     // read strobe
   input  mem_pkg::mem_addr_t rd_addr,
   output mem_pkg::mem_data_t rd_dout    // registered read word
);
   import mem_pkg::*;

   mem_data_t mem_q [MEM_DEPTH];         // the array itself

   // ####################
   // write port
   // ####################
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem_q[wr_addr] <= (mem_q[wr_addr] & ~wr_wem) | (wr_din & wr_wem); // masked bits only
      end
   end

   // ####################
   // read port
   // ####################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_dout <= '0;
      end else if (rd_en) begin
         rd_dout <= mem_q[rd_addr];       // one cycle latency
      end
   end

   // an unknown address would corrupt or read an arbitrary word
   a_wr_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
      wr_en |-> !$isunknown(wr_addr))
      else $error("mem_ram: write with unknown address");

   a_rd_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
      rd_en |-> !$isunknown(rd_addr))
      else $error("mem_ram: read with unknown address");

endmodule

//--- src/mem_subsys_top.sv
/*
  Memory subsystem top: dual port array with BIST.
  While BIST is busy, functional reads and writes are dropped and rd_dout
  keeps the last functional read word until the next functional read.
  All ports run on clk; rst_n is synchronous.
*/
`timescale 1ns/100ps

module mem_subsys_top (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               shutdown,
   input  logic               wr_en,
   input  mem_pkg::mem_data_t wr_wem,
   input  mem_pkg::mem_addr_t wr_addr,
   input  mem_pkg::mem_data_t wr_din,
   input  logic               rd_en,
   input  mem_pkg::mem_addr_t rd_addr,
   output mem_pkg::mem_data_t rd_dout,
   input  logic               bist_start,
   output logic               bist_busy,
   output logic               bist_done,
   output logic               bist_fail,
   output mem_pkg::mem_addr_t bist_fail_addr
);
   import mem_pkg::*;

   mem_bist_if  bist ();
   bist_state_t state;
   logic        addr_last;
   logic        chk_clear;
   mem_data_t   dp_dout;    // wrapper output, also seen by checker
   mem_data_t   hold_q;     // functional word parked during bist
   logic        view_q;     // rd_dout shows the parked word

   mem_dp u_dp (
      .clk      (clk),
      .rst_n    (rst_n),
      .shutdown (shutdown),
      .wr_en    (wr_en),
      .wr_wem   (wr_wem),
      .wr_addr  (wr_addr),
      .wr_din   (wr_din),
      .rd_en    (rd_en),
      .rd_addr  (rd_addr),
      .rd_dout  (dp_dout),
      .bist     (bist.mem)
   );

   mem_bist_ctrl u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .bist_start (bist_start),
      .addr_last  (addr_last),
      .state      (state),
      .bist_busy  (bist_busy),
      .bist_done  (bist_done),
      .chk_clear  (chk_clear)
   );

   mem_bist_pattern u_pattern (
      .clk       (clk),
      .rst_n     (rst_n),
      .state     (state),
      .addr_last (addr_last),
      .bist      (bist.gen)
   );

   mem_bist_check u_check (
      .clk            (clk),
      .rst_n          (rst_n),
      .clear          (chk_clear),
      .rd_dout        (dp_dout),
      .bist           (bist.chk),
      .bist_fail      (bist_fail),
      .bist_fail_addr (bist_fail_addr)
   );

   // ####################
   // rd_dout hold over bist
   // ####################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         view_q <= 1'b0;
      end else if (bist_busy) begin
         view_q <= 1'b1;                  // bist reads reuse the array register
      end else if (rd_en) begin
         view_q <= 1'b0;                  // fresh functional read
      end
   end

   always_ff @(posedge clk) begin
      if (!view_q) begin
         hold_q <= dp_dout;               // track until bist takes over
      end
   end

   assign rd_dout = view_q ? hold_q : dp_dout;

endmodule
